//--- verilog.f
logic/comparator_bus_pkg.sv
logic/fprint_arbiter.sv
logic/csr_arbiter.sv
logic/isr_sequencer.sv
logic/oflow_gate.sv
logic/comparator_bus_fabric.sv
tb/tb_comparator_bus_fabric.sv

//--- Bender.yml
package:
  name: comparator_bus_fabric

sources:
  - files:
      - logic/comparator_bus_pkg.sv
      - logic/fprint_arbiter.sv
      - logic/csr_arbiter.sv
      - logic/isr_sequencer.sv
      - logic/oflow_gate.sv
      - logic/comparator_bus_fabric.sv
  - target: test
    files:
      - tb/tb_comparator_bus_fabric.sv

//--- tb/tb_comparator_bus_fabric.sv
`timescale 1ns/100ps
`default_nettype none

module tb_comparator_bus_fabric import comparator_bus_pkg::*; ();

	localparam int masters = 16;
	localparam int aw = 10;
	localparam int period = 8;
	// 16 + 18 fingerprint, 14 + 3 + 16 CSR and 3 overflow transfers
	localparam int total_transfers = 70;
	localparam int timeout_cycles = 40 * total_transfers * 8;

	logic                            clk;
	logic                            reset;
	logic [masters-1:0]              m_fprint_write;
	logic [masters-1:0][aw-1:0]      m_fprint_address;
	logic [masters-1:0][31:0]        m_fprint_writedata;
	logic [masters-1:0]              m_fprint_waitrequest;
	logic [masters-1:0]              m_csr_write;
	logic [masters-1:0]              m_csr_read;
	logic [masters-1:0][aw-1:0]      m_csr_address;
	logic [masters-1:0][31:0]        m_csr_writedata;
	logic [masters-1:0]              m_csr_waitrequest;
	logic [31:0]                     m_csr_readdata;
	logic                            fprint_write;
	logic [aw-1:0]                   fprint_address;
	logic [31:0]                     fprint_writedata;
	logic                            fprint_waitrequest;
	logic                            csr_write;
	logic                            csr_read;
	logic [aw-1:0]                   csr_address;
	logic [31:0]                     csr_writedata;
	logic [31:0]                     csr_readdata;
	logic                            csr_waitrequest;
	logic                            irq;
	logic                            oflow_write;
	logic [31:0]                     oflow_address;
	logic [31:0]                     oflow_writedata;
	logic                            oflow_waitrequest;
	logic [masters-1:0]              core_enable;

	int fp_target [masters];
	int fp_done [masters];
	int csr_target [masters];
	int csr_done [masters];
	int fp_count;
	int csr_count;
	int service_count;
	int error_count = 0;
	logic [31:0] rng_state;
	logic [1:0] fp_left;
	logic [1:0] csr_left;
	logic irq_request;
	logic irq_raised;
	logic irq_clear;
	logic irq_q;
	logic [4:0] fp_pick;
	logic [4:0] fp_pick_q;
	logic [4:0] csr_pick;
	logic [4:0] csr_pick_q;
	logic [masters-1:0] exp_enable;

	comparator_bus_fabric #(
		.num_masters   (masters),
		.address_width (aw)
	) dut (.*);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// every master tags its address with its own index in the low nibble
	function automatic logic [aw-1:0] beat_address(input int m, input int beat);
		return {6'(beat), 4'(m)};
	endfunction

	function automatic logic [31:0] fprint_word(input int m, input int beat);
		return {8'hf0, 4'(m), 4'h0, 16'(beat * 7 + 1)};
	endfunction

	function automatic logic [31:0] csr_word(input int m, input int beat);
		return {8'hc5, 4'(m), 4'h3, 16'(beat * 13 + 5)};
	endfunction

	function automatic logic csr_is_read(input int m, input int beat);
		return ((m + beat) % 2) == 1;
	endfunction

	// status data the comparator model answers with for each CSR address
	function automatic logic [31:0] read_model(input logic [aw-1:0] address);
		return 32'hd00d_0000 | ({22'b0, address} * 32'd37);
	endfunction

	function automatic logic [4:0] first_set(input logic [masters-1:0] v);
		int i;
		i = 0;
		while (i < masters && !v[i])
			i++;
		return 5'(i);
	endfunction

	function automatic logic [aw-1:0] service_address(input int step);
		if (step == 0)
			return aw'(success_reg_offset);
		else if (step == 1)
			return aw'(fail_reg_offset);
		return aw'(exception_reg_offset);
	endfunction

	task automatic count_error(input string text);
		error_count++;
		$display("%s", text);
	endtask

	assign fp_pick = first_set(m_fprint_write & core_enable);
	assign csr_pick = first_set(m_csr_write | m_csr_read);

	// completion counters and the expected enable mask follow the rising edge
	always @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int m = 0; m < masters; m++) begin
				fp_done[m] <= 0;
				csr_done[m] <= 0;
			end
			fp_count <= 0;
			csr_count <= 0;
			service_count <= 0;
			exp_enable <= '1;
			irq_q <= 1'b0;
			fp_pick_q <= '0;
			csr_pick_q <= '0;
		end else begin
			for (int m = 0; m < masters; m++) begin
				if (m_fprint_write[m] && !m_fprint_waitrequest[m])
					fp_done[m] <= fp_done[m] + 1;
				if ((m_csr_write[m] || m_csr_read[m]) && !m_csr_waitrequest[m])
					csr_done[m] <= csr_done[m] + 1;
			end
			if (fprint_write && !fprint_waitrequest)
				fp_count <= fp_count + 1;
			if ((csr_write || csr_read) && !csr_waitrequest) begin
				csr_count <= csr_count + 1;
				if (irq)
					service_count <= service_count + 1;
			end
			if (oflow_write && oflow_waitrequest &&
				oflow_address == oflow_offset + (32'(oflow_writedata[7:4]) << oflow_core_shift))
				exp_enable[oflow_writedata[7:4]] <= !oflow_writedata[oflow_stall_bit];
			irq_q <= irq;
			fp_pick_q <= fp_pick;
			csr_pick_q <= csr_pick;
		end
	end

	// comparator model and master drivers, all on the falling edge
	initial begin
		m_fprint_write = '0;
		m_fprint_address = '0;
		m_fprint_writedata = '0;
		m_csr_write = '0;
		m_csr_read = '0;
		m_csr_address = '0;
		m_csr_writedata = '0;
		fprint_waitrequest = 1'b1;
		csr_waitrequest = 1'b1;
		csr_readdata = '0;
		irq = 1'b0;
		irq_raised = 1'b0;
		irq_clear = 1'b0;
		rng_state = 32'd88;
		fp_left = '0;
		csr_left = '0;
		forever begin
			@(negedge clk);
			if (fprint_write) begin
				if (fp_left == 0) begin
					fprint_waitrequest = 1'b0;
					rng_state = xorshift(rng_state);
					fp_left = rng_state[1:0];
				end else begin
					fprint_waitrequest = 1'b1;
					fp_left = fp_left - 1;
				end
			end else begin
				fprint_waitrequest = 1'b1;
			end
			// irq stays up until the exception write has completed
			if (irq_clear) begin
				irq = 1'b0;
				irq_clear = 1'b0;
			end else if (irq_request && !irq_raised && !csr_read && !csr_write) begin
				irq = 1'b1;
				irq_raised = 1'b1;
			end
			if (csr_read || csr_write) begin
				if (csr_left == 0) begin
					csr_waitrequest = 1'b0;
					rng_state = xorshift(rng_state);
					csr_left = rng_state[1:0];
					if (irq && csr_write && csr_address == aw'(exception_reg_offset))
						irq_clear = 1'b1;
				end else begin
					csr_waitrequest = 1'b1;
					csr_left = csr_left - 1;
				end
			end else begin
				csr_waitrequest = 1'b1;
			end
			csr_readdata = csr_read ? read_model(csr_address) : '0;
			for (int m = 0; m < masters; m++) begin
				m_fprint_write[m] = fp_done[m] < fp_target[m];
				m_fprint_address[m] = beat_address(m, fp_done[m]);
				m_fprint_writedata[m] = fprint_word(m, fp_done[m]);
				m_csr_read[m] = csr_done[m] < csr_target[m] && csr_is_read(m, csr_done[m]);
				m_csr_write[m] = csr_done[m] < csr_target[m] && !csr_is_read(m, csr_done[m]);
				m_csr_address[m] = beat_address(m, csr_done[m]);
				m_csr_writedata[m] = csr_word(m, csr_done[m]);
			end
		end
	end

	a_fprint_pick: assert property (@(posedge clk) disable iff (reset)
		$rose(fprint_write) |-> fprint_address[3:0] == fp_pick_q[3:0])
		else count_error($sformatf("error fprint_address %h expected master %h",
			fprint_address, fp_pick_q));

	a_fprint_single: assert property (@(posedge clk) disable iff (reset)
		$onehot0(~m_fprint_waitrequest))
		else count_error($sformatf("error m_fprint_waitrequest %h grants more than one master",
			m_fprint_waitrequest));

	a_fprint_idle: assert property (@(posedge clk) disable iff (reset)
		!fprint_write |-> fprint_address == '0 && fprint_writedata == '0 &&
			&m_fprint_waitrequest)
		else count_error($sformatf(
			"error fprint_address %h fprint_writedata %h m_fprint_waitrequest %h while idle",
			fprint_address, fprint_writedata, m_fprint_waitrequest));

	a_fprint_stable: assert property (@(posedge clk) disable iff (reset)
		(fprint_write && fprint_waitrequest)
			|=> $stable({fprint_write, fprint_address, fprint_writedata}))
		else count_error("the fingerprint port changed while the comparator held waitrequest");

	a_csr_pick: assert property (@(posedge clk) disable iff (reset)
		($rose(csr_read || csr_write) && !irq_q) |-> csr_address[3:0] == csr_pick_q[3:0])
		else count_error($sformatf("error csr_address %h expected master %h",
			csr_address, csr_pick_q));

	a_csr_idle: assert property (@(posedge clk) disable iff (reset)
		(!csr_read && !csr_write) |-> csr_address == '0 && csr_writedata == '0 &&
			&m_csr_waitrequest)
		else count_error($sformatf(
			"error csr_address %h csr_writedata %h m_csr_waitrequest %h while idle",
			csr_address, csr_writedata, m_csr_waitrequest));

	a_csr_stable: assert property (@(posedge clk) disable iff (reset)
		((csr_read || csr_write) && csr_waitrequest)
			|=> $stable({csr_read, csr_write, csr_address, csr_writedata}))
		else count_error("the CSR port changed while the comparator held waitrequest");

	a_isr_blocks: assert property (@(posedge clk) disable iff (reset)
		irq |-> &m_csr_waitrequest)
		else count_error($sformatf("error m_csr_waitrequest %h during interrupt service",
			m_csr_waitrequest));

	a_isr_order: assert property (@(posedge clk) disable iff (reset)
		(irq && (csr_read || csr_write) && !csr_waitrequest)
			|-> csr_address == service_address(service_count) &&
				csr_read == (service_count < 2) && csr_write == (service_count == 2) &&
				(service_count != 2 || csr_writedata == '0))
		else count_error($sformatf("error csr_address %h expected %h, csr_writedata %h",
			csr_address, service_address(service_count), csr_writedata));

	a_oflow_ack: assert property (@(posedge clk) disable iff (reset)
		(oflow_write && oflow_waitrequest) |=> !oflow_waitrequest)
		else count_error("an overflow write was not acknowledged on the next cycle");

	a_oflow_single: assert property (@(posedge clk) disable iff (reset)
		(!oflow_waitrequest || !oflow_write) |=> oflow_waitrequest)
		else count_error("overflow waitrequest went low without a fresh write");

	a_enable_mask: assert property (@(posedge clk) disable iff (reset)
		core_enable == exp_enable)
		else count_error($sformatf("error core_enable %h expected %h", core_enable, exp_enable));

	for (genvar m = 0; m < masters; m++) begin : g_master
		a_fprint_route: assert property (@(posedge clk) disable iff (reset)
			!m_fprint_waitrequest[m] |-> fprint_write && !fprint_waitrequest &&
				fprint_address == beat_address(m, fp_done[m]) &&
				fprint_writedata == fprint_word(m, fp_done[m]))
			else count_error($sformatf("error fprint_writedata %h expected %h, fprint_address %h",
				fprint_writedata, fprint_word(m, fp_done[m]), fprint_address));

		a_csr_write_route: assert property (@(posedge clk) disable iff (reset)
			(!m_csr_waitrequest[m] && m_csr_write[m]) |-> csr_write &&
				csr_address == beat_address(m, csr_done[m]) &&
				csr_writedata == csr_word(m, csr_done[m]))
			else count_error($sformatf("error csr_writedata %h expected %h, csr_address %h",
				csr_writedata, csr_word(m, csr_done[m]), csr_address));

		a_csr_read_data: assert property (@(posedge clk) disable iff (reset)
			(!m_csr_waitrequest[m] && m_csr_read[m]) |-> csr_read &&
				m_csr_readdata == read_model(beat_address(m, csr_done[m])))
			else count_error($sformatf("error m_csr_readdata %h expected %h",
				m_csr_readdata, read_model(beat_address(m, csr_done[m]))));
	end

	function automatic logic fprint_settled(input int skip);
		for (int m = 0; m < masters; m++)
			if (m != skip && fp_done[m] != fp_target[m])
				return 1'b0;
		return 1'b1;
	endfunction

	function automatic logic csr_settled();
		for (int m = 0; m < masters; m++)
			if (csr_done[m] != csr_target[m])
				return 1'b0;
		return 1'b1;
	endfunction

	task automatic start_fprint(input int first, input int last, input int beats);
		@(posedge clk);
		for (int m = first; m <= last; m++)
			fp_target[m] += beats;
	endtask

	task automatic start_csr(input int first, input int last, input int beats);
		@(posedge clk);
		for (int m = first; m <= last; m++)
			csr_target[m] += beats;
	endtask

	// holds the write until the gate acknowledges it, then lets go
	task automatic send_oflow(input logic [31:0] address, input logic [31:0] data);
		@(negedge clk);
		oflow_write = 1'b1;
		oflow_address = address;
		oflow_writedata = data;
		do
			@(negedge clk);
		while (oflow_waitrequest);
		@(negedge clk);
		oflow_write = 1'b0;
		oflow_address = '0;
		oflow_writedata = '0;
	endtask

	initial begin
		reset = 1'b1;
		oflow_write = 1'b0;
		oflow_address = '0;
		oflow_writedata = '0;
		irq_request = 1'b0;
		for (int m = 0; m < masters; m++) begin
			fp_target[m] = 0;
			csr_target[m] = 0;
		end
		repeat (16) @(negedge clk);
		reset = 1'b0;
		repeat (4) @(negedge clk);

		// eight fingerprint masters collide in the same cycle
		start_fprint(0, 7, 2);
		while (!fprint_settled(-1))
			@(negedge clk);

		// stall core 2, then a write outside its window that must change nothing
		send_oflow(oflow_offset + (32'd2 << oflow_core_shift), 32'h0000_0120);
		send_oflow(oflow_offset + (32'd5 << oflow_core_shift), 32'h0000_0130);
		start_fprint(0, 5, 3);
		while (!fprint_settled(2))
			@(negedge clk);
		repeat (12) @(negedge clk);
		assert (fp_done[2] == fp_target[2] - 3)
			else count_error("core 2 was granted while its fingerprint enable was cleared");
		send_oflow(oflow_offset + (32'd2 << oflow_core_shift), 32'h0000_0020);
		while (!fprint_settled(-1))
			@(negedge clk);

		// interrupt arrives while CSR masters are waiting
		start_csr(3, 9, 2);
		irq_request = 1'b1;
		// the service is over once the sequencer drops its busy flag
		do
			@(negedge clk);
		while (!dut.isr_busy);
		do
			@(negedge clk);
		while (dut.isr_busy);
		assert (service_count == 3)
			else count_error($sformatf("error service_count %h expected %h", service_count, 3));
		while (!csr_settled())
			@(negedge clk);

		// mixed reads and writes from every CSR master
		start_csr(0, masters - 1, 1);
		while (!csr_settled())
			@(negedge clk);
		repeat (8) @(negedge clk);

		$display("run finished with %0d errors over %0d fingerprint and %0d CSR transfers",
			error_count, fp_count, csr_count);
		if (error_count == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	initial begin
		repeat (timeout_cycles) @(posedge clk);
		$display("timeout: the stimulus did not complete within %0d cycles", timeout_cycles);
		$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- logic/comparator_bus_fabric.sv
`timescale 1ns/100ps
`default_nettype none

module comparator_bus_fabric import comparator_bus_pkg::*; #(
	parameter int num_masters = 16,
	parameter int address_width = 10
) (
	input  logic                                        clk,
	input  logic                                        reset,
	input  logic [num_masters-1:0]                      m_fprint_write,
	input  logic [num_masters-1:0][address_width-1:0]   m_fprint_address,
	input  logic [num_masters-1:0][data_width-1:0]      m_fprint_writedata,
	output logic [num_masters-1:0]                      m_fprint_waitrequest,
	input  logic [num_masters-1:0]                      m_csr_write,
	input  logic [num_masters-1:0]                      m_csr_read,
	input  logic [num_masters-1:0][address_width-1:0]   m_csr_address,
	input  logic [num_masters-1:0][data_width-1:0]      m_csr_writedata,
	output logic [num_masters-1:0]                      m_csr_waitrequest,
	output logic [data_width-1:0]                       m_csr_readdata,
	output logic                                        fprint_write,
	output logic [address_width-1:0]                    fprint_address,
	output logic [data_width-1:0]                       fprint_writedata,
	input  logic                                        fprint_waitrequest,
	output logic                                        csr_write,
	output logic                                        csr_read,
	output logic [address_width-1:0]                    csr_address,
	output logic [data_width-1:0]                       csr_writedata,
	input  logic [data_width-1:0]                       csr_readdata,
	input  logic                                        csr_waitrequest,
	input  logic                                        irq,
	input  logic                                        oflow_write,
	input  logic [data_width-1:0]                       oflow_address,
	input  logic [data_width-1:0]                       oflow_writedata,
	output logic                                        oflow_waitrequest,
	output logic [num_masters-1:0]                      core_enable
);

	// interrupt service port between the sequencer and the CSR arbiter
	logic                     isr_read;
	logic                     isr_write;
	logic [address_width-1:0] isr_address;
	logic [data_width-1:0]    isr_writedata;
	logic                     isr_waitrequest;
	logic [data_width-1:0]    isr_readdata;
	logic                     isr_busy;

	fprint_arbiter #(
		.num_masters   (num_masters),
		.address_width (address_width)
	) u_fprint_arbiter (
		.clk                  (clk),
		.reset                (reset),
		.m_fprint_write       (m_fprint_write),
		.m_fprint_address     (m_fprint_address),
		.m_fprint_writedata   (m_fprint_writedata),
		.m_fprint_waitrequest (m_fprint_waitrequest),
		.fprint_write         (fprint_write),
		.fprint_address       (fprint_address),
		.fprint_writedata     (fprint_writedata),
		.fprint_waitrequest   (fprint_waitrequest),
		.core_enable          (core_enable)
	);

	csr_arbiter #(
		.num_masters   (num_masters),
		.address_width (address_width)
	) u_csr_arbiter (
		.clk               (clk),
		.reset             (reset),
		.m_csr_write       (m_csr_write),
		.m_csr_read        (m_csr_read),
		.m_csr_address     (m_csr_address),
		.m_csr_writedata   (m_csr_writedata),
		.m_csr_waitrequest (m_csr_waitrequest),
		.m_csr_readdata    (m_csr_readdata),
		.isr_read          (isr_read),
		.isr_write         (isr_write),
		.isr_address       (isr_address),
		.isr_writedata     (isr_writedata),
		.isr_waitrequest   (isr_waitrequest),
		.isr_readdata      (isr_readdata),
		.csr_write         (csr_write),
		.csr_read          (csr_read),
		.csr_address       (csr_address),
		.csr_writedata     (csr_writedata),
		.csr_readdata      (csr_readdata),
		.csr_waitrequest   (csr_waitrequest),
		.irq               (irq)
	);

	isr_sequencer #(
		.address_width (address_width)
	) u_isr_sequencer (
		.clk             (clk),
		.reset           (reset),
		.irq             (irq),
		.isr_read        (isr_read),
		.isr_write       (isr_write),
		.isr_address     (isr_address),
		.isr_writedata   (isr_writedata),
		.isr_waitrequest (isr_waitrequest),
		.isr_readdata    (isr_readdata),
		.isr_busy        (isr_busy)
	);

	oflow_gate #(
		.num_masters (num_masters)
	) u_oflow_gate (
		.clk               (clk),
		.reset             (reset),
		.oflow_write       (oflow_write),
		.oflow_address     (oflow_address),
		.oflow_writedata   (oflow_writedata),
		.oflow_waitrequest (oflow_waitrequest),
		.core_enable       (core_enable)
	);

endmodule

`default_nettype wire

//--- logic/oflow_gate.sv
`timescale 1ns/100ps
`default_nettype none

module oflow_gate import comparator_bus_pkg::*; #(
	parameter int num_masters = 16
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   oflow_write,
	input  logic [data_width-1:0]  oflow_address,
	input  logic [data_width-1:0]  oflow_writedata,
	output logic                   oflow_waitrequest,
	output logic [num_masters-1:0] core_enable
);

	logic                  ack;
	logic [key_width-1:0]  core_index;
	logic                  stall;
	logic [data_width-1:0] expected_address;
	logic                  address_match;

	assign core_index = oflow_writedata[key_width +: key_width];
	assign stall = oflow_writedata[oflow_stall_bit];

	// each core owns one address in the overflow window
	assign expected_address = oflow_offset + (data_width'(core_index) << oflow_core_shift);
	assign address_match = (oflow_address == expected_address) &&
		(int'(core_index) < num_masters);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ack <= 1'b0;
			core_enable <= '1;
		end else begin
			// the cycle with ack high completes the write, so it is not sampled again
			ack <= oflow_write && !ack;
			if (oflow_write && !ack && address_match)
				core_enable[core_index] <= !stall;
		end
	end

	assign oflow_waitrequest = !ack;

	a_single_ack: assert property (@(posedge clk) disable iff (reset)
		!oflow_waitrequest |=> oflow_waitrequest)
		else $error("overflow waitrequest low for two cycles");

endmodule

`default_nettype wire

//--- logic/isr_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module isr_sequencer import comparator_bus_pkg::*; #(
	parameter int address_width = 10
) (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     irq,
	output logic                     isr_read,
	output logic                     isr_write,
	output logic [address_width-1:0] isr_address,
	output logic [data_width-1:0]    isr_writedata,
	input  logic                     isr_waitrequest,
	input  logic [data_width-1:0]    isr_readdata,
	output logic                     isr_busy
);

	localparam logic [1:0] step_idle = 2'd0;
	localparam logic [1:0] step_success = 2'd1;
	localparam logic [1:0] step_fail = 2'd2;
	localparam logic [1:0] step_exception = 2'd3;

	logic [1:0] step;
	logic       irq_q;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			step <= step_idle;
			irq_q <= 1'b0;
		end else begin
			irq_q <= irq;
			case (step)
				step_idle: begin
					// a new rising edge only counts once the last service is over
					if (irq && !irq_q)
						step <= step_success;
				end
				step_success: if (!isr_waitrequest) step <= step_fail;
				step_fail: if (!isr_waitrequest) step <= step_exception;
				default: if (!isr_waitrequest) step <= step_idle;
			endcase
		end
	end

	always_comb begin
		isr_read = 1'b0;
		isr_write = 1'b0;
		isr_address = '0;
		case (step)
			step_success: begin
				isr_read = 1'b1;
				isr_address = address_width'(success_reg_offset);
			end
			step_fail: begin
				isr_read = 1'b1;
				isr_address = address_width'(fail_reg_offset);
			end
			step_exception: begin
				isr_write = 1'b1;
				isr_address = address_width'(exception_reg_offset);
			end
			default: begin
				isr_read = 1'b0;
				isr_write = 1'b0;
			end
		endcase
	end

	// clearing the exception register is always a write of zero
	assign isr_writedata = '0;
	assign isr_busy = (step != step_idle);

	// the service port carries a read or a write, never both
	a_read_write_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(isr_read && isr_write))
		else $error("service port read and write asserted together");

	a_readdata_known: assert property (@(posedge clk) disable iff (reset)
		(isr_read && !isr_waitrequest) |-> !$isunknown(isr_readdata))
		else $error("comparator returned unknown status data");

endmodule

`default_nettype wire

//--- logic/csr_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module csr_arbiter import comparator_bus_pkg::*; #(
	parameter int num_masters = 16,
	parameter int address_width = 10
) (
	input  logic                                        clk,
	input  logic                                        reset,
	input  logic [num_masters-1:0]                      m_csr_write,
	input  logic [num_masters-1:0]                      m_csr_read,
	input  logic [num_masters-1:0][address_width-1:0]   m_csr_address,
	input  logic [num_masters-1:0][data_width-1:0]      m_csr_writedata,
	output logic [num_masters-1:0]                      m_csr_waitrequest,
	output logic [data_width-1:0]                       m_csr_readdata,
	input  logic                                        isr_read,
	input  logic                                        isr_write,
	input  logic [address_width-1:0]                    isr_address,
	input  logic [data_width-1:0]                       isr_writedata,
	output logic                                        isr_waitrequest,
	output logic [data_width-1:0]                       isr_readdata,
	output logic                                        csr_write,
	output logic                                        csr_read,
	output logic [address_width-1:0]                    csr_address,
	output logic [data_width-1:0]                       csr_writedata,
	input  logic [data_width-1:0]                       csr_readdata,
	input  logic                                        csr_waitrequest,
	input  logic                                        irq
);

	arb_state_t             state;
	logic [key_width-1:0]   grant;
	logic [max_masters-1:0] request_wide;
	logic                   request_found;
	logic [key_width-1:0]   request_index;

	always_comb begin
		request_wide = '0;
		request_wide[num_masters-1:0] = m_csr_write | m_csr_read;
		request_found = lowest_request(request_wide, request_index);
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= arb_idle;
			grant <= '0;
		end else begin
			case (state)
				arb_idle: begin
					// a pending interrupt wins over every master
					if (irq) begin
						state <= arb_isr;
					end else if (request_found) begin
						state <= arb_busy;
						grant <= request_index;
					end
				end
				arb_busy: begin
					if (!csr_waitrequest)
						state <= arb_idle;
				end
				arb_isr: begin
					// the service port keeps the bus until the comparator drops irq
					if (!irq)
						state <= arb_idle;
				end
				default: state <= arb_idle;
			endcase
		end
	end

	always_comb begin
		case (state)
			arb_busy: begin
				csr_write = m_csr_write[grant];
				csr_read = m_csr_read[grant];
				csr_address = m_csr_address[grant];
				csr_writedata = m_csr_writedata[grant];
			end
			arb_isr: begin
				csr_write = isr_write;
				csr_read = isr_read;
				csr_address = isr_address;
				csr_writedata = isr_writedata;
			end
			default: begin
				csr_write = 1'b0;
				csr_read = 1'b0;
				csr_address = '0;
				csr_writedata = '0;
			end
		endcase
	end

	always_comb begin
		m_csr_waitrequest = '1;
		if (state == arb_busy)
			m_csr_waitrequest[grant] = csr_waitrequest;
	end

	assign isr_waitrequest = (state == arb_isr) ? csr_waitrequest : 1'b1;

	// read data goes to everyone, each reader qualifies it with its own waitrequest
	assign m_csr_readdata = csr_readdata;
	assign isr_readdata = csr_readdata;

	a_isr_blocks_masters: assert property (@(posedge clk) disable iff (reset)
		(state == arb_isr) |-> &m_csr_waitrequest)
		else $error("CSR master released during interrupt service");

endmodule

`default_nettype wire

//--- logic/fprint_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module fprint_arbiter import comparator_bus_pkg::*; #(
	parameter int num_masters = 16,
	parameter int address_width = 10
) (
	input  logic                                        clk,
	input  logic                                        reset,
	input  logic [num_masters-1:0]                      m_fprint_write,
	input  logic [num_masters-1:0][address_width-1:0]   m_fprint_address,
	input  logic [num_masters-1:0][data_width-1:0]      m_fprint_writedata,
	output logic [num_masters-1:0]                      m_fprint_waitrequest,
	output logic                                        fprint_write,
	output logic [address_width-1:0]                    fprint_address,
	output logic [data_width-1:0]                       fprint_writedata,
	input  logic                                        fprint_waitrequest,
	input  logic [num_masters-1:0]                      core_enable
);

	arb_state_t             state;
	logic [key_width-1:0]   grant;
	logic [max_masters-1:0] request_wide;
	logic                   request_found;
	logic [key_width-1:0]   request_index;

	// stalled cores are masked out before the priority pick
	always_comb begin
		request_wide = '0;
		request_wide[num_masters-1:0] = m_fprint_write & core_enable;
		request_found = lowest_request(request_wide, request_index);
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= arb_idle;
			grant <= '0;
		end else begin
			case (state)
				arb_idle: begin
					if (request_found) begin
						state <= arb_busy;
						grant <= request_index;
					end
				end
				arb_busy: begin
					// the transfer completes at this edge, then one idle cycle
					if (!fprint_waitrequest)
						state <= arb_idle;
				end
				default: state <= arb_idle;
			endcase
		end
	end

	// comparator side carries the granted master, zero when nothing is granted
	always_comb begin
		if (state == arb_busy) begin
			fprint_write = m_fprint_write[grant];
			fprint_address = m_fprint_address[grant];
			fprint_writedata = m_fprint_writedata[grant];
		end else begin
			fprint_write = 1'b0;
			fprint_address = '0;
			fprint_writedata = '0;
		end
	end

	always_comb begin
		m_fprint_waitrequest = '1;
		if (state == arb_busy)
			m_fprint_waitrequest[grant] = fprint_waitrequest;
	end

	property p_grant_enabled;
		logic [num_masters-1:0] enable_at_pick;
		(state == arb_idle, enable_at_pick = core_enable) ##1 (state == arb_busy)
			|-> enable_at_pick[grant];
	endproperty

	a_grant_enabled: assert property (@(posedge clk) disable iff (reset) p_grant_enabled)
		else $error("fingerprint grant issued to disabled core %0d", grant);

	// the granted master must hold its request steady under back-pressure
	a_stable_under_wait: assert property (@(posedge clk) disable iff (reset)
		(state == arb_busy && fprint_waitrequest)
			|=> $stable({fprint_write, fprint_address, fprint_writedata}))
		else $error("fingerprint bus changed while waitrequest was high");

endmodule

`default_nettype wire

//--- logic/comparator_bus_pkg.sv
`default_nettype none

package comparator_bus_pkg;

	// every data word on the fingerprint, CSR and overflow buses
	localparam int data_width = 32;

	// a core or task index
	localparam int key_width = 4;

	// widest request vector the priority pick can take
	localparam int max_masters = 2 ** key_width;

	// status and exception registers visited by the interrupt service
	localparam int unsigned success_reg_offset = 'h3f0;
	localparam int unsigned fail_reg_offset = 'h3f4;
	localparam int unsigned exception_reg_offset = 'h3f8;

	// overflow writes land in a window above this base
	localparam logic [data_width-1:0] oflow_offset = 32'h0800_0000;

	// the core index sits at this bit of an overflow address
	localparam int oflow_core_shift = 20;

	// stall flag in overflow write data, just above the core index field
	localparam int oflow_stall_bit = 8;

	typedef enum logic [1:0] {
		arb_idle = 2'd0,
		arb_busy = 2'd1,
		arb_isr  = 2'd2
	} arb_state_t;

	// lowest set bit of a request vector, found is low when nothing is requested
	function automatic logic lowest_request(
		input  logic [max_masters-1:0] request,
		output logic [key_width-1:0]   index
	);
		logic found;
		found = 1'b0;
		index = '0;
		// scan downward so the lowest index is the last one kept
		for (int i = max_masters - 1; i >= 0; i--) begin
			if (request[i]) begin
				found = 1'b1;
				index = key_width'(i);
			end
		end
		return found;
	endfunction

endpackage

`default_nettype wire
